// ==== src/daq_macros.svh ====
`ifndef DAQ_MACROS_SVH
`define DAQ_MACROS_SVH

////////////////////
// Word widths
`define WORD_W      16          // Readout and command word
`define HDR_W       8           // Header byte
`define OPC_W       4           // Opcode field at top of command word

////////////////////
// Host opcodes
`define OPC_HEADER  4'hA        // Load header byte
`define OPC_CHAN    4'hB        // Select readout chain
`define OPC_CLEAR   4'hC        // Flush FIFO and overflow flag

// Upper byte of every header word
`define FRAME_MARK  8'hA5

////////////////////
// Output buffer
`define FIFO_DEPTH  16
`define CREDIT_INIT 4           // Credits held after reset
`define CREDIT_W    3

`endif

// ==== src/daqCmdPkg.sv ====
`include "daq_macros.svh"

// Types seen on the host command path
package daqCmdPkg;

    // Raw control word from host
    typedef logic [`WORD_W-1:0] cmdWord_t;

    // Opcode in top nibble of a command word
    typedef enum logic [`OPC_W-1:0] {
        OpIdle   = {`OPC_W{1'b0}},  // No word offered
        OpHeader = `OPC_HEADER,
        OpChan   = `OPC_CHAN,
        OpClear  = `OPC_CLEAR
    } opcode_t;

    // Event header value
    // Lands in low byte of the header word
    typedef logic [`HDR_W-1:0] headerByte_t;

endpackage

// ==== src/daqDataPkg.sv ====
`include "daq_macros.svh"

// Types seen on the readout data path
package daqDataPkg;

    // One readout word of header or ASIC data
    typedef logic [`WORD_W-1:0] dataWord_t;

    // Bit position inside a word being assembled
    // Wraps after the last bit of a word
    typedef logic [$clog2(`WORD_W)-1:0] bitCount_t;

endpackage

// ==== src/cmdDecoder.sv ====
`timescale 1ns/100ps
`include "daq_macros.svh"

module cmdDecoder import daqCmdPkg::*; (
    input  logic        Clk,
    input  logic        rst,
    input  logic        cmdValid,     // Host word strobe that never stalls
    input  cmdWord_t    cmdWord,
    output headerByte_t headerByte,   // Low byte of header word
    output logic        chainSel,     // 1 picks chain 1, 0 picks chain 2
    output logic        clearPulse    // One cycle flush request
);

    opcode_t     opcode;
    headerByte_t dataField;

    ////////////////////
    // Field split

    // Idle when nothing offered
    assign opcode    = cmdValid ? opcode_t'(cmdWord[`WORD_W-1 -: `OPC_W]) : OpIdle;
    assign dataField = cmdWord[`HDR_W-1:0];   // Argument byte

    ////////////////////
    // Config registers

    always_ff @(posedge Clk) begin
        if (rst) begin
            headerByte <= '0;
            chainSel   <= 1'b1;               // Chain 1 after reset
            clearPulse <= 1'b0;
        end else begin
            clearPulse <= 1'b0;               // Single cycle only
            case (opcode)
                OpHeader: headerByte <= dataField;
                OpChan:   chainSel   <= dataField[0];
                OpClear:  clearPulse <= 1'b1;
                default:  ;                   // Unknown opcodes ignored
            endcase
        end
    end

endmodule

// ==== src/serialDeserializer.sv ====
`timescale 1ns/100ps
`include "daq_macros.svh"

module serialDeserializer import daqDataPkg::*; (
    input  logic      Clk,
    input  logic      rst,
    input  logic      chainSel,       // 1 chain 1, 0 chain 2
    input  logic      dout1b,         // Active low serial data
    input  logic      dout2b,
    input  logic      transmiton1b,   // Active low transmission window
    input  logic      transmiton2b,
    output logic      frameStart,     // Start of a transmission
    output logic      wordValid,
    output dataWord_t wordData
);

    logic                txOn;        // Selected window in true polarity
    logic                txOnPrev;
    logic                serBit;      // Selected data bit in true polarity
    logic [`WORD_W-2:0]  shiftReg;    // Bits before the last of a word
    bitCount_t           bitCnt;
    logic                lastBit;

    // Chain mux
    assign txOn    = chainSel ? ~transmiton1b : ~transmiton2b;
    assign serBit  = chainSel ? ~dout1b : ~dout2b;
    assign lastBit = txOn && (bitCnt == bitCount_t'(`WORD_W - 1));   // Word complete

    ////////////////////
    // Start detection

    always_ff @(posedge Clk) begin
        if (rst) begin
            txOnPrev   <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            txOnPrev   <= txOn;
            frameStart <= txOn && !txOnPrev;  // Falling edge of transmiton
        end
    end

    ////////////////////
    // Word assembly

    // Restarts whenever the window closes, so partial words vanish
    always_ff @(posedge Clk) begin
        if (rst || !txOn)
            bitCnt <= '0;
        else
            bitCnt <= bitCnt + 1'b1;          // Wraps to 0 after last bit
    end

    always_ff @(posedge Clk) begin
        if (txOn)
            shiftReg <= {shiftReg[`WORD_W-3:0], serBit};   // MSB first
    end

    always_ff @(posedge Clk) begin
        if (rst)
            wordValid <= 1'b0;
        else
            wordValid <= lastBit;
    end

    // Final bit joins straight from the line
    always_ff @(posedge Clk) begin
        if (lastBit)
            wordData <= {shiftReg, serBit};
    end

endmodule

// ==== src/frameHeaderInserter.sv ====
`timescale 1ns/100ps
`include "daq_macros.svh"

module frameHeaderInserter import daqCmdPkg::*, daqDataPkg::*; (
    input  logic        Clk,
    input  logic        rst,
    input  headerByte_t headerByte,   // From host config
    input  logic        frameStart,
    input  logic        wordValid,
    input  dataWord_t   wordData,
    output logic        pushValid,    // To output FIFO
    output dataWord_t   pushData
);

    dataWord_t headerWord;

    // Mark byte on top, host byte below
    assign headerWord = {`FRAME_MARK, headerByte};

    ////////////////////
    // Merged stream

    always_ff @(posedge Clk) begin
        if (rst)
            pushValid <= 1'b0;
        else
            pushValid <= frameStart || wordValid;
    end

    // Header and data are at least a word apart on the line,
    // so both strobes never land in one cycle
    always_ff @(posedge Clk) begin
        if (frameStart)
            pushData <= headerWord;           // Leads each frame
        else if (wordValid)
            pushData <= wordData;
    end

endmodule

// ==== src/creditFifo.sv ====
`timescale 1ns/100ps
`include "daq_macros.svh"

module creditFifo import daqDataPkg::*; #(
    parameter int DEPTH   = `FIFO_DEPTH,  // Power of two
    parameter int CREDITS = `CREDIT_INIT  // Host buffer slots at start
) (
    input  logic      Clk,
    input  logic      rst,
    input  logic      clearPulse,     // Flush contents and overflow
    input  logic      pushValid,
    input  dataWord_t pushData,
    input  logic      outCredit,      // One slot freed on host side
    output logic      outValid,
    output dataWord_t outData,
    output logic      overflow        // Sticky until clear
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;     // Holds DEPTH itself
    localparam int CRD_W = `CREDIT_W;

    dataWord_t          mem [DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;            // Words held
    logic [CRD_W-1:0]   credits;          // Sends still allowed
    logic               full;
    logic               doPush;
    logic               doSend;

    assign full   = (count == CNT_W'(DEPTH));
    assign doPush = pushValid && !full && !clearPulse;          // ASIC can't wait
    assign doSend = (count != '0) && (credits != '0) && !clearPulse;

    ////////////////////
    // Storage

    always_ff @(posedge Clk) begin
        if (doPush)
            mem[wrPtr] <= pushData;
        if (doSend)
            outData <= mem[rdPtr];            // Valid with outValid
    end

    ////////////////////
    // Pointers

    always_ff @(posedge Clk) begin
        if (rst || clearPulse) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;        // Wraps at DEPTH
            if (doSend)
                rdPtr <= rdPtr + 1'b1;
            count <= count + CNT_W'(doPush) - CNT_W'(doSend);
        end
    end

    ////////////////////
    // Flow control

    // Clear leaves credits alone since sent words still hold host slots
    always_ff @(posedge Clk) begin
        if (rst)
            credits <= CRD_W'(CREDITS);
        else
            credits <= credits + CRD_W'(outCredit) - CRD_W'(doSend);
    end

    always_ff @(posedge Clk) begin
        if (rst || clearPulse) begin
            outValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            outValid <= doSend;               // One pulse per word
            if (pushValid && full)
                overflow <= 1'b1;             // Word lost
        end
    end

endmodule

// ==== src/readoutTop.sv ====
`timescale 1ns/100ps
`include "daq_macros.svh"

module readoutTop import daqCmdPkg::*, daqDataPkg::*; (
    input  logic      Clk,
    input  logic      rst,
    // Host control words
    input  logic      cmdValid,
    input  cmdWord_t  cmdWord,
    // Active low ASIC readout pins
    input  logic      dout1b,
    input  logic      dout2b,
    input  logic      transmiton1b,
    input  logic      transmiton2b,
    // Host data side
    input  logic      outCredit,
    output logic      outValid,
    output dataWord_t outData,
    output logic      overflow
);

    headerByte_t headerByte;
    logic        chainSel;
    logic        clearPulse;
    logic        frameStart;
    logic        wordValid;
    dataWord_t   wordData;
    logic        pushValid;
    dataWord_t   pushData;

    cmdDecoder i_cmdDecoder (
        .Clk        (Clk),
        .rst        (rst),
        .cmdValid   (cmdValid),
        .cmdWord    (cmdWord),
        .headerByte (headerByte),
        .chainSel   (chainSel),
        .clearPulse (clearPulse)
    );

    serialDeserializer i_serialDeserializer (
        .Clk          (Clk),
        .rst          (rst),
        .chainSel     (chainSel),
        .dout1b       (dout1b),
        .dout2b       (dout2b),
        .transmiton1b (transmiton1b),
        .transmiton2b (transmiton2b),
        .frameStart   (frameStart),
        .wordValid    (wordValid),
        .wordData     (wordData)
    );

    frameHeaderInserter i_frameHeaderInserter (
        .Clk        (Clk),
        .rst        (rst),
        .headerByte (headerByte),
        .frameStart (frameStart),
        .wordValid  (wordValid),
        .wordData   (wordData),
        .pushValid  (pushValid),
        .pushData   (pushData)
    );

    creditFifo #(
        .DEPTH   (`FIFO_DEPTH),
        .CREDITS (`CREDIT_INIT)
    ) i_creditFifo (
        .Clk        (Clk),
        .rst        (rst),
        .clearPulse (clearPulse),
        .pushValid  (pushValid),
        .pushData   (pushData),
        .outCredit  (outCredit),
        .outValid   (outValid),
        .outData    (outData),
        .overflow   (overflow)
    );

endmodule

// ==== dv/readoutTb.sv ====
`timescale 1ns/100ps
`include "daq_macros.svh"

module readoutTb import daqCmdPkg::*, daqDataPkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;        // Input skew after rising edge
    localparam int PHASES     = 6;
    localparam int PHASE_CYC  = 2000;     // Watchdog budget per phase

    logic        Clk;
    logic        rst;
    logic        cmdValid;
    cmdWord_t    cmdWord;
    logic        dout1b;
    logic        dout2b;
    logic        transmiton1b;
    logic        transmiton2b;
    logic        outCredit;
    logic        outValid;
    dataWord_t   outData;
    logic        overflow;

    // Scoreboard state
    dataWord_t   expMem [0:511];          // Predicted output words
    int          expCnt;                  // Words predicted so far
    int          rdIdx;                   // Words seen at output
    int          retCnt;                  // Credits seen by DUT
    logic        creditEn;                // Host returns credits
    headerByte_t hdrModel;                // Header byte last written

    readoutTop i_readoutTop (.*);

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic stopOnError(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "Stopped on first error");
    endtask

    ////////////////////
    // Output monitor

    always @(posedge Clk) begin
        if (rst) begin
            rdIdx  <= 0;
            retCnt <= 0;
        end else begin
            if (outValid)
                rdIdx <= rdIdx + 1;
            if (outCredit)
                retCnt <= retCnt + 1;
        end
    end

    // Oldest predicted word must come out next
    aOrder: assert property (@(posedge Clk) disable iff (rst)
        outValid |-> (rdIdx < expCnt) && (outData == expMem[rdIdx]))
        else stopOnError($sformatf("outData %h at output word %0d", outData, rdIdx));

    // Never more sends than credits granted
    aCredit: assert property (@(posedge Clk) disable iff (rst)
        outValid |-> (rdIdx < `CREDIT_INIT + retCnt))
        else stopOnError($sformatf("send %0d with %0d credits returned", rdIdx, retCnt));

    aReset: assert property (@(posedge Clk) rst |=> !outValid && !overflow)
        else stopOnError("outValid or overflow set out of reset");

    ////////////////////
    // Host credit model

    initial begin : hostCredit
        int gap;
        gap       = 0;
        outCredit = 1'b0;
        forever begin
            @(posedge Clk);
            #DRIVE_DLY;
            outCredit = 1'b0;
            if (gap > 0)
                gap--;                                  // Random pause between credits
            else if (creditEn && (rdIdx - retCnt) > 0) begin
                outCredit = 1'b1;                       // Give back one slot
                gap       = int'($urandom % 4);
            end
        end
    end

    task automatic nextCycle();
        @(posedge Clk);
        #DRIVE_DLY;
    endtask

    task automatic sendCmd(input logic [`OPC_W-1:0] opc, input headerByte_t arg);
        cmdValid = 1'b1;
        cmdWord  = {opc, {(`WORD_W - `OPC_W - `HDR_W){1'b0}}, arg};
        nextCycle();
        cmdValid = 1'b0;
        cmdWord  = '0;
        if (opc == `OPC_HEADER)
            hdrModel = arg;                             // Next frames carry this byte
    endtask

    ////////////////////
    // ASIC serial model

    task automatic driveLine(input int chain, input logic txb, input logic db);
        if (chain == 1) begin
            transmiton1b = txb;
            dout1b       = db;
        end else begin
            transmiton2b = txb;
            dout2b       = db;
        end
    endtask

    // Sends words MSB first with an optional partial tail
    task automatic transmitFrame(input int chain, input int nWords, input int tailBits,
                                 input bit expectOut);
        dataWord_t w;
        int        stop;
        if (expectOut) begin
            expMem[expCnt] = {`FRAME_MARK, hdrModel};   // Header leads the frame
            expCnt++;
        end
        for (int n = 0; n <= nWords; n++) begin
            w    = dataWord_t'($urandom);
            stop = (n == nWords) ? `WORD_W - tailBits : 0;   // Tail is partial or empty
            if (expectOut && n < nWords) begin
                expMem[expCnt] = w;
                expCnt++;
            end
            for (int b = `WORD_W - 1; b >= stop; b--) begin
                driveLine(chain, 1'b0, ~w[b]);          // Line level is inverted
                nextCycle();
            end
        end
        driveLine(chain, 1'b1, 1'b1);
        repeat (4) nextCycle();                         // Pipeline to FIFO output
    endtask

    // All predicted words out and all credits back
    task automatic waitDrained();
        int cyc;
        cyc = 0;
        while ((rdIdx != expCnt || retCnt != rdIdx) && cyc < PHASE_CYC) begin
            nextCycle();
            cyc++;
        end
        if (rdIdx != expCnt || retCnt != rdIdx)
            stopOnError($sformatf("%0d of %0d words seen", rdIdx, expCnt));
    endtask

    ////////////////////
    // Test sequence

    initial begin : mainSeq
        int base;
        void'($urandom(58741));
        rst          = 1'b1;
        cmdValid     = 1'b0;
        cmdWord      = '0;
        dout1b       = 1'b1;
        dout2b       = 1'b1;
        transmiton1b = 1'b1;                            // Both chains idle
        transmiton2b = 1'b1;
        creditEn     = 1'b1;
        expCnt       = 0;
        hdrModel     = '0;
        repeat (8) @(posedge Clk);
        #DRIVE_DLY;
        rst = 1'b0;
        nextCycle();
        assert (!outValid && !overflow) else stopOnError("outputs active after reset");

        // Header then three words on chain 1
        sendCmd(`OPC_HEADER, 8'h3C);
        transmitFrame(1, 3, 0, 1'b1);
        waitDrained();

        // Chain 2 selected while chain 1 is ignored
        sendCmd(`OPC_CHAN, 8'h00);
        transmitFrame(2, 2, 0, 1'b1);
        transmitFrame(1, 2, 0, 1'b0);
        waitDrained();
        sendCmd(`OPC_CHAN, 8'h01);

        // Partial tail is dropped
        sendCmd(`OPC_HEADER, 8'h5A);
        transmitFrame(1, 2, 7, 1'b1);
        waitDrained();

        // Credits withheld
        creditEn = 1'b0;
        base     = rdIdx;
        transmitFrame(1, 7, 0, 1'b1);
        assert (rdIdx - base == `CREDIT_INIT)
            else stopOnError($sformatf("%0d words sent without credit", rdIdx - base));
        assert (!overflow) else stopOnError("overflow set with room left");
        creditEn = 1'b1;
        waitDrained();

        // Overrun the buffer so excess words are lost
        creditEn = 1'b0;
        transmitFrame(1, 23, 0, 1'b1);
        expCnt = expCnt - (24 - (`CREDIT_INIT + `FIFO_DEPTH));
        assert (overflow) else stopOnError("overflow not set after overrun");
        creditEn = 1'b1;
        waitDrained();
        assert (overflow) else stopOnError("overflow not sticky");

        // Clear flushes stored words
        creditEn = 1'b0;
        transmitFrame(1, 5, 0, 1'b1);
        sendCmd(`OPC_CLEAR, 8'h00);
        expCnt = rdIdx;                                 // Stored words discarded
        nextCycle();
        assert (!overflow) else stopOnError("overflow still set after clear");
        creditEn = 1'b1;
        transmitFrame(1, 2, 0, 1'b1);
        waitDrained();

        $display("TEST PASS");
        $finish;
    end

    initial begin : watchdog
        #(PHASES * PHASE_CYC * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", PHASES * PHASE_CYC);
        $display("TEST FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== sim.f ====
+incdir+src
src/daqCmdPkg.sv
src/daqDataPkg.sv
src/cmdDecoder.sv
src/serialDeserializer.sv
src/frameHeaderInserter.sv
src/creditFifo.sv
src/readoutTop.sv
dv/readoutTb.sv

// ==== Makefile ====
# Verilator build and run for the readout front end
TOP       ?= readoutTb
SEED      ?= 58741
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: build
	$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f sim.f

clean:
	rm -rf $(OBJ_DIR) $(LOG)
